// File: bench/arm_core_properties.sv
module arm_core_properties (
	input logic clk,
	input logic rstn,
	input arm_pkg::word_t o_mem_addr,
	input arm_pkg::word_t o_mem_wdata,
	input logic o_mem_read,
	input logic o_mem_write,
	input logic i_mem_ok
);

	a_one_strobe: assert property (@(posedge clk) !(o_mem_read && o_mem_write))
		else $error("read and write strobes high together");

	// strobes drop right after a reset edge
	a_reset_idle: assert property (@(posedge clk) !rstn |=> !o_mem_read && !o_mem_write)
		else $error("strobe high after a reset cycle");

	a_stable_wait: assert property (@(posedge clk) disable iff (!rstn)
		(o_mem_read || o_mem_write) && !i_mem_ok
		|=> $stable(o_mem_addr) && (!o_mem_write || $stable(o_mem_wdata)))
		else $error("address or write data moved while waiting for mem_ok");

	a_fetch_aligned: assert property (@(posedge clk) disable iff (!rstn)
		o_mem_read |-> o_mem_addr[1:0] == 2'b00)
		else $error("read address not word aligned");

endmodule

bind arm_core arm_core_properties u_props (.*);

// File: bench/arm_core_tb.sv
module arm_core_tb;
	import arm_pkg::*;

	localparam word_t RESET_PC = 32'h0000_0100;
	localparam word_t DATA_BASE = 32'h0000_0800;  // result slots addressed through r11
	localparam word_t DONE_ADDR = 32'h0000_0ffc;
	localparam word_t POISON = DATA_BASE + 32'h200;  // skipped stores
	localparam int MAX_CYCLES = 20000;  // six programs of under 80 words with 2 waits per access

	logic clk = 1'b0;
	logic rstn = 1'b0;
	logic i_mem_ok = 1'b0;
	word_t i_mem_rdata = '0;
	word_t o_mem_addr;
	word_t o_mem_wdata;
	logic o_mem_read;
	logic o_mem_write;

	word_t mem [0:1023];
	word_t image [0:1023];  // copied into mem during reset
	logic [1:0] wait_left = 2'd0;
	logic done = 1'b0;
	int cycles = 0;
	int n_checks = 0;
	int n_errs = 0;
	int n_tests = 0;
	word_t prog[$];
	word_t exp_val[$];
	word_t exp_addr[$];
	word_t rd_q[$];
	word_t data_q[$];

	arm_core #(.RESET_PC(RESET_PC)) uut (
		.clk(clk), .rstn(rstn), .o_mem_addr(o_mem_addr), .o_mem_wdata(o_mem_wdata),
		.i_mem_rdata(i_mem_rdata), .o_mem_read(o_mem_read), .o_mem_write(o_mem_write),
		.i_mem_ok(i_mem_ok)
	);

	always #50 clk = ~clk;

	// memory model with 0 to 2 wait cycles per access
	always @(posedge clk) begin
		if (!rstn) begin
			i_mem_ok <= 1'b0;
			mem <= image;
		end else if ((o_mem_read || o_mem_write) && !i_mem_ok) begin
			if (wait_left == 2'd0) begin
				i_mem_ok <= 1'b1;
				i_mem_rdata <= mem[o_mem_addr[11:2]];
				if (o_mem_write) begin
					mem[o_mem_addr[11:2]] <= o_mem_wdata;
				end
			end else begin
				wait_left <= wait_left - 2'd1;
			end
		end else begin
			i_mem_ok <= 1'b0;
			wait_left <= 2'($urandom % 3);
		end
	end

	// fetches sit below the data area
	always @(posedge clk) begin
		if (!rstn) begin
			done <= 1'b0;
			rd_q.delete();
			data_q.delete();
		end else if (i_mem_ok && (o_mem_read || o_mem_write)) begin
			if (o_mem_read && o_mem_addr < DATA_BASE) begin
				rd_q.push_back(o_mem_addr);
			end else begin
				data_q.push_back(o_mem_addr);
			end
			if (o_mem_write && o_mem_addr == DONE_ADDR) begin
				done <= 1'b1;
			end
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout, the program never reached the done address");
			$display("Testbench failed");
			$finish;
		end
	end

	function automatic word_t dp_imm(alu_op_t op, logic s, reg_sel_t rn, reg_sel_t rd,
		logic [3:0] rot, logic [7:0] imm);
		return {4'he, 3'b001, op, s, rn, rd, rot, imm};
	endfunction

	function automatic word_t dp_sh(alu_op_t op, logic s, reg_sel_t rn, reg_sel_t rd,
		logic [4:0] amt, shift_t kind, reg_sel_t rm);
		return {4'he, 3'b000, op, s, rn, rd, amt, kind, 1'b0, rm};
	endfunction

	function automatic word_t dp_rs(alu_op_t op, reg_sel_t rd, reg_sel_t rs, shift_t kind,
		reg_sel_t rm);
		return {4'he, 3'b000, op, 1'b0, 4'd0, rd, rs, 1'b0, kind, 1'b1, rm};
	endfunction

	function automatic word_t ldst(logic l, logic p, logic u, logic w, reg_sel_t rn,
		reg_sel_t rd, logic [11:0] off);
		return {4'he, 3'b010, p, u, 1'b0, w, l, rn, rd, off};
	endfunction

	function automatic word_t ldst_reg(logic l, reg_sel_t rn, reg_sel_t rd, logic [4:0] amt,
		reg_sel_t rm);
		return {4'he, 3'b011, 2'b11, 2'b00, l, rn, rd, amt, 2'b00, 1'b0, rm};  // pre, up, lsl
	endfunction

	function automatic word_t branch(logic link, logic [23:0] off);
		return {4'he, 3'b101, link, off};
	endfunction

	function automatic word_t with_cond(cond_t c, word_t w);
		return {c, w[27:0]};
	endfunction

	function automatic void put(word_t w);
		prog.push_back(w);
	endfunction

	function automatic void xfer(word_t w, word_t addr);
		prog.push_back(w);
		exp_addr.push_back(addr);
	endfunction

	function automatic void store_slot(reg_sel_t r, word_t expv);
		int slot;
		slot = exp_val.size();
		xfer(ldst(1'b0, 1'b1, 1'b1, 1'b0, 4'd11, r, 12'(slot * 4)), DATA_BASE + 32'(slot * 4));
		exp_val.push_back(expv);
	endfunction

	function automatic void begin_prog();
		prog.delete();
		exp_val.delete();
		exp_addr.delete();
		put(dp_imm(OP_MOV, 1'b0, 4'd0, 4'd11, 4'd14, 8'h80));  // r11 = 0x800
	endfunction

	function automatic void cond_mov(cond_t c, word_t expv);
		put(dp_imm(OP_MOV, 1'b0, 4'd0, 4'd8, 4'd0, 8'h00));
		put(with_cond(c, dp_imm(OP_MOV, 1'b0, 4'd0, 4'd8, 4'd0, 8'h01)));
		store_slot(4'd8, expv);
	endfunction

	task automatic check_word(string name, word_t got, word_t expv);
		n_checks++;
		if (got !== expv) begin
			n_errs++;
			$display("** Error: %s = %h, expected %h", name, got, expv);
		end
	endtask

	task automatic check_addr(string name, word_t got, word_t expv);
		n_checks++;
		if (got !== expv) begin
			n_errs++;
			$display("** Error: %s address = %h, expected %h", name, got, expv);
		end
	endtask

	// appends the done store then runs the program and checks results
	task automatic run_prog();
		put(dp_imm(OP_MOV, 1'b0, 4'd0, 4'd12, 4'd14, 8'hff));
		xfer(ldst(1'b0, 1'b1, 1'b1, 1'b0, 4'd12, 4'd0, 12'h00c), DONE_ADDR);
		for (int i = 0; i < 1024; i++) begin
			image[i] = ~(32'(i) << 2);  // nv condition never executes
		end
		foreach (prog[i]) begin
			image[RESET_PC[11:2] + 10'(i)] = prog[i];
		end
		rstn <= 1'b0;
		repeat (3) @(posedge clk);
		rstn <= 1'b1;
		while (!done) begin
			@(posedge clk);
		end
		rstn <= 1'b0;
		foreach (exp_val[i]) begin
			check_word($sformatf("slot %0d", i), mem[DATA_BASE[11:2] + 10'(i)], exp_val[i]);
		end
		if (data_q.size() != exp_addr.size()) begin
			n_errs++;
			$display("data access count is %0d, expected %0d", data_q.size(), exp_addr.size());
		end else begin
			foreach (exp_addr[i]) begin
				check_addr($sformatf("data access %0d", i), data_q[i], exp_addr[i]);
			end
		end
	endtask

	task automatic check_fetches(int n);
		if (rd_q.size() < n) begin
			n_errs++;
			$display("only %0d fetches seen, expected %0d", rd_q.size(), n);
		end else begin
			for (int i = 0; i < n; i++) begin
				check_addr("fetch", rd_q[i], RESET_PC + 32'(4 * i));
			end
		end
	endtask

	task automatic report(string name, int errs_before);
		n_tests++;
		if (n_errs == errs_before) begin
			$display("%s: ok", name);
		end else begin
			$display("%s: %0d errors", name, n_errs - errs_before);
		end
	endtask

	task automatic reset_fetch();
		int e;
		e = n_errs;
		begin_prog();
		put(dp_imm(OP_MOV, 1'b0, 4'd0, 4'd1, 4'd0, 8'h01));
		put(dp_imm(OP_MOV, 1'b0, 4'd0, 4'd2, 4'd0, 8'h02));
		store_slot(4'd2, 32'd2);
		run_prog();
		check_fetches(prog.size());
		report("reset_fetch", e);
	endtask

	task automatic data_proc();
		int e;
		word_t a, b, v;
		e = n_errs;
		a = 32'd5;
		b = 32'd3;
		v = 32'hff00_0081;
		begin_prog();
		put(dp_imm(OP_MOV, 1'b0, 4'd0, 4'd0, 4'd4, 8'hff));  // 0xff ror 8
		store_slot(4'd0, 32'hff00_0000);
		put(dp_imm(OP_MOV, 1'b0, 4'd0, 4'd1, 4'd0, 8'h05));
		put(dp_imm(OP_MOV, 1'b0, 4'd0, 4'd2, 4'd0, 8'h03));
		put(dp_sh(OP_ADD, 1'b0, 4'd1, 4'd3, 5'd0, SH_LSL, 4'd2));
		store_slot(4'd3, a + b);
		put(dp_sh(OP_SUB, 1'b0, 4'd1, 4'd4, 5'd0, SH_LSL, 4'd2));
		store_slot(4'd4, a - b);
		put(dp_sh(OP_RSB, 1'b0, 4'd1, 4'd5, 5'd0, SH_LSL, 4'd2));
		store_slot(4'd5, b - a);
		put(dp_sh(OP_CMP, 1'b1, 4'd1, 4'd0, 5'd0, SH_LSL, 4'd2));  // no borrow sets c
		put(dp_sh(OP_ADC, 1'b0, 4'd1, 4'd6, 5'd0, SH_LSL, 4'd2));
		store_slot(4'd6, a + b + 32'd1);
		put(dp_sh(OP_SBC, 1'b0, 4'd1, 4'd7, 5'd0, SH_LSL, 4'd2));
		store_slot(4'd7, a - b);
		put(dp_sh(OP_AND, 1'b0, 4'd1, 4'd8, 5'd0, SH_LSL, 4'd2));
		store_slot(4'd8, a & b);
		put(dp_sh(OP_ORR, 1'b0, 4'd1, 4'd8, 5'd0, SH_LSL, 4'd2));
		store_slot(4'd8, a | b);
		put(dp_sh(OP_EOR, 1'b0, 4'd1, 4'd8, 5'd0, SH_LSL, 4'd2));
		store_slot(4'd8, a ^ b);
		put(dp_sh(OP_BIC, 1'b0, 4'd1, 4'd8, 5'd0, SH_LSL, 4'd2));
		store_slot(4'd8, a & ~b);
		put(dp_sh(OP_MVN, 1'b0, 4'd0, 4'd8, 5'd0, SH_LSL, 4'd2));
		store_slot(4'd8, ~b);
		put(dp_imm(OP_ORR, 1'b0, 4'd0, 4'd9, 4'd0, 8'h81));
		put(dp_sh(OP_MOV, 1'b0, 4'd0, 4'd8, 5'd4, SH_LSL, 4'd9));
		store_slot(4'd8, v << 4);
		put(dp_sh(OP_MOV, 1'b0, 4'd0, 4'd8, 5'd4, SH_LSR, 4'd9));
		store_slot(4'd8, v >> 4);
		put(dp_sh(OP_MOV, 1'b0, 4'd0, 4'd8, 5'd4, SH_ASR, 4'd9));
		store_slot(4'd8, {{4{v[31]}}, v[31:4]});
		put(dp_sh(OP_MOV, 1'b0, 4'd0, 4'd8, 5'd4, SH_ROR, 4'd9));
		store_slot(4'd8, {v[3:0], v[31:4]});
		put(dp_sh(OP_MOV, 1'b0, 4'd0, 4'd8, 5'd0, SH_ROR, 4'd9));  // rrx with c = 1
		store_slot(4'd8, {1'b1, v[31:1]});
		put(dp_imm(OP_MOV, 1'b0, 4'd0, 4'd10, 4'd0, 8'h08));
		put(dp_rs(OP_MOV, 4'd8, 4'd10, SH_LSL, 4'd9));
		store_slot(4'd8, v << 8);
		put(dp_rs(OP_MOV, 4'd8, 4'd10, SH_LSR, 4'd9));
		store_slot(4'd8, v >> 8);
		put(dp_rs(OP_MOV, 4'd8, 4'd10, SH_ASR, 4'd9));
		store_slot(4'd8, {{8{v[31]}}, v[31:8]});
		put(dp_rs(OP_MOV, 4'd8, 4'd10, SH_ROR, 4'd9));
		store_slot(4'd8, {v[7:0], v[31:8]});
		run_prog();
		report("data_proc", e);
	endtask

	task automatic flags_cond();
		int e;
		e = n_errs;
		begin_prog();
		put(dp_imm(OP_MOV, 1'b0, 4'd0, 4'd1, 4'd0, 8'h05));
		put(dp_imm(OP_MOV, 1'b0, 4'd0, 4'd2, 4'd0, 8'h03));
		put(dp_imm(OP_MOV, 1'b0, 4'd0, 4'd13, 4'd1, 8'h01));  // 0x4000_0000
		put(dp_sh(OP_CMP, 1'b1, 4'd1, 4'd0, 5'd0, SH_LSL, 4'd2));  // nzcv 0010
		cond_mov(COND_EQ, 32'd0);
		cond_mov(COND_NE, 32'd1);
		cond_mov(COND_CS, 32'd1);
		cond_mov(COND_HI, 32'd1);
		cond_mov(COND_GE, 32'd1);
		cond_mov(COND_LT, 32'd0);
		put(dp_sh(OP_CMP, 1'b1, 4'd2, 4'd0, 5'd0, SH_LSL, 4'd1));  // nzcv 1000
		cond_mov(COND_MI, 32'd1);
		cond_mov(COND_CC, 32'd1);
		cond_mov(COND_LS, 32'd1);
		cond_mov(COND_LT, 32'd1);
		cond_mov(COND_GT, 32'd0);
		cond_mov(COND_LE, 32'd1);
		put(dp_sh(OP_CMN, 1'b1, 4'd13, 4'd0, 5'd0, SH_LSL, 4'd13));  // nzcv 1001
		cond_mov(COND_VS, 32'd1);
		cond_mov(COND_VC, 32'd0);
		cond_mov(COND_GE, 32'd1);
		cond_mov(COND_PL, 32'd0);
		put(dp_imm(OP_TST, 1'b1, 4'd1, 4'd0, 4'd0, 8'h02));  // nzcv 0101
		cond_mov(COND_EQ, 32'd1);
		cond_mov(COND_VS, 32'd1);
		cond_mov(COND_CS, 32'd0);
		put(dp_imm(OP_MOV, 1'b0, 4'd0, 4'd9, 4'd0, 8'h07));
		put(with_cond(COND_NE, dp_imm(OP_MOV, 1'b1, 4'd0, 4'd9, 4'd0, 8'h05)));
		cond_mov(COND_EQ, 32'd1);
		store_slot(4'd9, 32'd7);
		put(dp_sh(OP_TEQ, 1'b1, 4'd1, 4'd0, 5'd0, SH_LSL, 4'd2));
		cond_mov(COND_NE, 32'd1);
		run_prog();
		report("flags_cond", e);
	endtask

	task automatic branches();
		int e;
		word_t bl_addr;
		e = n_errs;
		begin_prog();
		put(branch(1'b0, 24'd0));  // target is two words ahead
		put(ldst(1'b0, 1'b1, 1'b1, 1'b0, 4'd11, 4'd0, 12'h200));
		put(dp_imm(OP_MOV, 1'b0, 4'd0, 4'd8, 4'd0, 8'h11));
		store_slot(4'd8, 32'h11);
		bl_addr = RESET_PC + 32'(4 * prog.size());
		put(branch(1'b1, 24'd0));
		put(ldst(1'b0, 1'b1, 1'b1, 1'b0, 4'd11, 4'd0, 12'h200));
		store_slot(4'd14, bl_addr + 32'd4);
		run_prog();
		foreach (data_q[i]) begin
			if (data_q[i] == POISON) begin
				n_errs++;
				$display("a store behind a taken branch reached the bus");
			end
		end
		report("branch", e);
	endtask

	task automatic load_store();
		int e;
		word_t base;
		e = n_errs;
		base = DATA_BASE + 32'h100;
		begin_prog();
		put(dp_imm(OP_MOV, 1'b0, 4'd0, 4'd1, 4'd0, 8'h40));
		put(dp_imm(OP_ADD, 1'b0, 4'd11, 4'd2, 4'd12, 8'h01));  // r2 = base
		put(dp_imm(OP_MOV, 1'b0, 4'd0, 4'd3, 4'd0, 8'h55));
		put(dp_imm(OP_MOV, 1'b0, 4'd0, 4'd4, 4'd0, 8'h03));
		xfer(ldst(1'b0, 1'b1, 1'b1, 1'b0, 4'd2, 4'd3, 12'd8), base + 32'd8);
		xfer(ldst(1'b0, 1'b1, 1'b1, 1'b1, 4'd2, 4'd3, 12'd4), base + 32'd4);
		base = base + 32'd4;
		xfer(ldst(1'b0, 1'b0, 1'b1, 1'b0, 4'd2, 4'd1, 12'h10), base);  // post-index
		base = base + 32'h10;
		store_slot(4'd2, base);
		xfer(ldst(1'b0, 1'b1, 1'b0, 1'b0, 4'd2, 4'd3, 12'd8), base - 32'd8);
		xfer(ldst_reg(1'b0, 4'd2, 4'd3, 5'd2, 4'd4), base + 32'd12);
		xfer(ldst(1'b1, 1'b1, 1'b0, 1'b0, 4'd2, 4'd5, 12'h10), base - 32'h10);
		store_slot(4'd5, 32'h40);
		xfer(ldst(1'b1, 1'b1, 1'b0, 1'b1, 4'd2, 4'd2, 12'd8), base - 32'd8);
		store_slot(4'd2, 32'h55);  // the loaded value beats writeback
		run_prog();
		check_word("mem[0x920]", mem[10'h248], 32'h55);
		check_word("mem[0x908]", mem[10'h242], 32'h55);
		report("load_store", e);
	endtask

	task automatic undefined_nop();
		int e;
		e = n_errs;
		begin_prog();
		put(dp_imm(OP_MOV, 1'b0, 4'd0, 4'd8, 4'd0, 8'h33));
		store_slot(4'd8, 32'h33);
		put(32'he10f_8000);  // mrs r8, cpsr
		put(32'he89b_0100);  // ldm r11, {r8}
		put(32'he5db_8000);  // ldrb r8, [r11]
		store_slot(4'd8, 32'h33);
		run_prog();
		check_fetches(prog.size());
		report("undefined_nop", e);
	endtask

	initial begin
		void'($urandom(32'hfaf1_32d2));
		reset_fetch();
		data_proc();
		flags_cond();
		branches();
		load_store();
		undefined_nop();
		$display("%0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errs);
		if (n_errs == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

// File: common/arm_pkg.sv
package arm_pkg;

	typedef logic [31:0] word_t;    // data, address or instruction
	typedef logic [3:0] reg_sel_t;  // register number, 15 is the pc
	typedef logic [3:0] flags_t;    // {n, z, c, v}

	// bit positions inside flags_t
	localparam int FLAG_N = 3;
	localparam int FLAG_Z = 2;
	localparam int FLAG_C = 1;
	localparam int FLAG_V = 0;

	typedef enum logic [1:0] {
		SH_LSL = 2'b00,
		SH_LSR = 2'b01,
		SH_ASR = 2'b10,
		SH_ROR = 2'b11
	} shift_t;

	// architectural data-processing opcodes, instr[24:21]
	typedef enum logic [3:0] {
		OP_AND = 4'b0000,
		OP_EOR = 4'b0001,
		OP_SUB = 4'b0010,
		OP_RSB = 4'b0011,
		OP_ADD = 4'b0100,
		OP_ADC = 4'b0101,
		OP_SBC = 4'b0110,
		OP_RSC = 4'b0111,
		OP_TST = 4'b1000,
		OP_TEQ = 4'b1001,
		OP_CMP = 4'b1010,
		OP_CMN = 4'b1011,
		OP_ORR = 4'b1100,
		OP_MOV = 4'b1101,
		OP_BIC = 4'b1110,
		OP_MVN = 4'b1111
	} alu_op_t;

	typedef enum logic [3:0] {
		COND_EQ = 4'h0,
		COND_NE = 4'h1,
		COND_CS = 4'h2,
		COND_CC = 4'h3,
		COND_MI = 4'h4,
		COND_PL = 4'h5,
		COND_VS = 4'h6,
		COND_VC = 4'h7,
		COND_HI = 4'h8,
		COND_LS = 4'h9,
		COND_GE = 4'ha,
		COND_LT = 4'hb,
		COND_GT = 4'hc,
		COND_LE = 4'hd,
		COND_AL = 4'he
	} cond_t;

	typedef enum logic [2:0] {
		ST_INIT,
		ST_FETCH,
		ST_DECODE,
		ST_EXEC
	} cpu_state_t;

	localparam word_t PC_AHEAD = 32'd8;     // r15 reads two words ahead
	localparam word_t INSTR_BYTES = 32'd4;
	localparam reg_sel_t REG_PC = 4'd15;
	localparam reg_sel_t REG_LR = 4'd14;    // bl return address

endpackage

// File: common/reg_port_if.sv
interface reg_port_if;
	import arm_pkg::*;

	reg_sel_t rn_sel;
	reg_sel_t rm_sel;
	reg_sel_t rs_sel;
	reg_sel_t rd_sel;
	word_t rn_val;
	word_t rm_val;
	word_t rs_val;
	word_t rd_val;
	word_t pc;        // current instruction address

	logic wr_en;      // result / load port
	reg_sel_t wr_sel;
	word_t wr_data;
	logic base_en;    // base writeback port
	reg_sel_t base_sel;
	word_t base_data;
	logic pc_en;      // sequential pc update
	word_t pc_data;

	modport ctrl (
		output rn_sel, rm_sel, rs_sel, rd_sel,
		input rn_val, rm_val, rs_val, rd_val, pc,
		output wr_en, wr_sel, wr_data, base_en, base_sel, base_data, pc_en, pc_data
	);

	modport rf (
		input rn_sel, rm_sel, rs_sel, rd_sel,
		output rn_val, rm_val, rs_val, rd_val, pc,
		input wr_en, wr_sel, wr_data, base_en, base_sel, base_data, pc_en, pc_data
	);

endinterface

// File: execute/arm_alu.sv
module arm_alu (
	input arm_pkg::alu_op_t i_op,
	input arm_pkg::word_t i_a,
	input arm_pkg::word_t i_b,
	input arm_pkg::flags_t i_flags,
	input logic i_shift_carry,
	output arm_pkg::word_t o_result,
	output arm_pkg::flags_t o_flags,
	output logic o_writes_rd
);
	import arm_pkg::*;

	logic arith;         // adder result selected
	word_t add_x;
	word_t add_y;
	logic add_cin;
	logic [32:0] sum;
	word_t logic_res;

	// subtraction is x + ~y + 1, so carry out is the not-borrow
	always_comb begin
		arith = 1'b1;
		add_x = i_a;
		add_y = i_b;
		add_cin = 1'b0;
		logic_res = '0;
		case (i_op)
			OP_AND, OP_TST: begin
				arith = 1'b0;
				logic_res = i_a & i_b;
			end
			OP_EOR, OP_TEQ: begin
				arith = 1'b0;
				logic_res = i_a ^ i_b;
			end
			OP_ORR: begin
				arith = 1'b0;
				logic_res = i_a | i_b;
			end
			OP_MOV: begin
				arith = 1'b0;
				logic_res = i_b;
			end
			OP_BIC: begin
				arith = 1'b0;
				logic_res = i_a & ~i_b;
			end
			OP_MVN: begin
				arith = 1'b0;
				logic_res = ~i_b;
			end
			OP_SUB, OP_CMP: begin
				add_y = ~i_b;
				add_cin = 1'b1;
			end
			OP_RSB: begin
				add_x = ~i_a;
				add_cin = 1'b1;
			end
			OP_ADC: add_cin = i_flags[FLAG_C];
			OP_SBC: begin
				add_y = ~i_b;
				add_cin = i_flags[FLAG_C];
			end
			OP_RSC: begin
				add_x = ~i_a;
				add_cin = i_flags[FLAG_C];
			end
			default: add_cin = 1'b0;  // add, cmn
		endcase
	end

	assign sum = {1'b0, add_x} + {1'b0, add_y} + {32'd0, add_cin};
	assign o_result = arith ? sum[31:0] : logic_res;

	assign o_flags[FLAG_N] = o_result[31];
	assign o_flags[FLAG_Z] = (o_result == '0);
	assign o_flags[FLAG_C] = arith ? sum[32] : i_shift_carry;
	assign o_flags[FLAG_V] = arith ? ((add_x[31] == add_y[31]) && (sum[31] != add_x[31]))
		: i_flags[FLAG_V];  // logical ops keep v

	assign o_writes_rd = !(i_op inside {OP_TST, OP_TEQ, OP_CMP, OP_CMN});

endmodule

// File: execute/arm_shifter.sv
module arm_shifter (
	input logic i_imm_form,
	input arm_pkg::word_t i_value,
	input logic [7:0] i_amount,
	input arm_pkg::shift_t i_kind,
	input logic i_carry_in,
	output arm_pkg::word_t o_operand,
	output logic o_carry
);
	import arm_pkg::*;

	logic [8:0] eff;  // lsr/asr count, a zero count means 32

	function automatic word_t ror32(word_t v, logic [4:0] n);
		return (v >> n) | (v << (6'd32 - {1'b0, n}));
	endfunction

	assign eff = (i_amount == 8'd0) ? 9'd32 : {1'b0, i_amount};

	// a count of zero here is always the immediate form, the control
	// unit turns a register shift by zero into lsl 0
	always_comb begin
		o_operand = i_value;
		o_carry = i_carry_in;
		if (i_imm_form) begin
			o_operand = ror32(i_value, i_amount[4:0]);
			if (i_amount != 8'd0) begin
				o_carry = o_operand[31];
			end
		end else begin
			case (i_kind)
				SH_LSL: begin
					if (i_amount == 8'd0) begin
						o_operand = i_value;  // no shift
					end else if (i_amount < 8'd32) begin
						o_operand = i_value << i_amount[4:0];
						o_carry = i_value[32 - i_amount[4:0]];
					end else begin
						o_operand = '0;
						o_carry = (i_amount == 8'd32) ? i_value[0] : 1'b0;
					end
				end
				SH_LSR: begin
					if (eff < 9'd32) begin
						o_operand = i_value >> eff[4:0];
						o_carry = i_value[eff[4:0] - 5'd1];
					end else begin
						o_operand = '0;
						o_carry = (eff == 9'd32) ? i_value[31] : 1'b0;
					end
				end
				SH_ASR: begin
					if (eff < 9'd32) begin
						o_operand = $signed(i_value) >>> eff[4:0];
						o_carry = i_value[eff[4:0] - 5'd1];
					end else begin
						o_operand = {32{i_value[31]}};  // saturates to sign
						o_carry = i_value[31];
					end
				end
				SH_ROR: begin
					if (i_amount == 8'd0) begin
						o_operand = {i_carry_in, i_value[31:1]};  // rrx
						o_carry = i_value[0];
					end else if (i_amount[4:0] == 5'd0) begin
						o_carry = i_value[31];  // multiple of 32
					end else begin
						o_operand = ror32(i_value, i_amount[4:0]);
						o_carry = i_value[i_amount[4:0] - 5'd1];
					end
				end
			endcase
		end
	end

endmodule

// File: hw/arm_control.sv
module arm_control #(
	parameter arm_pkg::word_t RESET_PC = 32'h0800_0000
) (
	input logic clk,
	input logic rstn,
	reg_port_if.ctrl regs,
	output logic o_sh_imm_form,
	output arm_pkg::word_t o_sh_value,
	output logic [7:0] o_sh_amount,
	output arm_pkg::shift_t o_sh_kind,
	input arm_pkg::word_t i_sh_operand,
	input logic i_sh_carry,
	output arm_pkg::alu_op_t o_alu_op,
	output arm_pkg::word_t o_alu_a,
	output arm_pkg::word_t o_alu_b,
	input arm_pkg::word_t i_alu_result,
	input arm_pkg::flags_t i_alu_flags,
	input logic i_alu_writes_rd,
	output arm_pkg::flags_t o_flags,
	output arm_pkg::word_t o_mem_addr,
	output arm_pkg::word_t o_mem_wdata,
	input arm_pkg::word_t i_mem_rdata,
	output logic o_mem_read,
	output logic o_mem_write,
	input logic i_mem_ok
);
	import arm_pkg::*;

	cpu_state_t state, state_d;
	word_t ir, ir_d;      // instruction register
	flags_t nzcv, nzcv_d;

	logic is_dp, is_br, is_ls, reg_shift, cond_pass;
	word_t seq_pc, ls_offset, off_addr, xfer_addr;

	function automatic logic cond_ok(cond_t c, flags_t f);
		case (c)
			COND_EQ: return f[FLAG_Z];
			COND_NE: return !f[FLAG_Z];
			COND_CS: return f[FLAG_C];
			COND_CC: return !f[FLAG_C];
			COND_MI: return f[FLAG_N];
			COND_PL: return !f[FLAG_N];
			COND_VS: return f[FLAG_V];
			COND_VC: return !f[FLAG_V];
			COND_HI: return f[FLAG_C] && !f[FLAG_Z];
			COND_LS: return !f[FLAG_C] || f[FLAG_Z];
			COND_GE: return f[FLAG_N] == f[FLAG_V];
			COND_LT: return f[FLAG_N] != f[FLAG_V];
			COND_GT: return !f[FLAG_Z] && (f[FLAG_N] == f[FLAG_V]);
			COND_LE: return f[FLAG_Z] || (f[FLAG_N] != f[FLAG_V]);
			COND_AL: return 1'b1;
			default: return 1'b0;  // nv space
		endcase
	endfunction

	// class decode, everything else runs as a no-op
	assign is_dp = (ir[27:26] == 2'b00) && !(!ir[25] && ir[7] && ir[4])
		&& !((ir[24:23] == 2'b10) && !ir[20]);  // mrs, msr, bx
	assign is_br = (ir[27:25] == 3'b101);
	assign is_ls = (ir[27:26] == 2'b01) && !ir[22] && !(ir[25] && ir[4]);
	assign cond_pass = cond_ok(cond_t'(ir[31:28]), nzcv);

	assign regs.rn_sel = ir[19:16];
	assign regs.rd_sel = ir[15:12];
	assign regs.rs_sel = ir[11:8];
	assign regs.rm_sel = ir[3:0];

	// operand 2, the same shifter scales the ldr/str register offset
	assign reg_shift = is_dp && !ir[25] && ir[4];
	assign o_sh_imm_form = is_dp && ir[25];
	assign o_sh_value = o_sh_imm_form ? {24'd0, ir[7:0]} : regs.rm_val;
	assign o_sh_amount = o_sh_imm_form ? {3'd0, ir[11:8], 1'b0}
		: reg_shift ? regs.rs_val[7:0] : {3'd0, ir[11:7]};
	assign o_sh_kind = (reg_shift && regs.rs_val[7:0] == 8'd0) ? SH_LSL : shift_t'(ir[6:5]);

	assign o_alu_op = alu_op_t'(ir[24:21]);
	assign o_alu_a = regs.rn_val;
	assign o_alu_b = i_sh_operand;
	assign o_flags = nzcv;

	assign seq_pc = regs.pc + INSTR_BYTES;
	assign ls_offset = ir[25] ? i_sh_operand : {20'd0, ir[11:0]};
	assign off_addr = ir[23] ? regs.rn_val + ls_offset : regs.rn_val - ls_offset;
	assign xfer_addr = ir[24] ? off_addr : regs.rn_val;  // post-index uses old base

	always_comb begin
		state_d = state;
		ir_d = ir;
		nzcv_d = nzcv;
		regs.wr_en = 1'b0;
		regs.wr_sel = ir[15:12];
		regs.wr_data = i_alu_result;
		regs.base_en = 1'b0;
		regs.base_sel = ir[19:16];
		regs.base_data = off_addr;
		regs.pc_en = 1'b0;
		regs.pc_data = seq_pc;
		o_mem_addr = regs.pc;
		o_mem_wdata = regs.rd_val;
		o_mem_read = 1'b0;
		o_mem_write = 1'b0;
		case (state)
			ST_INIT: begin
				regs.pc_en = 1'b1;
				regs.pc_data = RESET_PC;
				nzcv_d = '0;
				state_d = ST_FETCH;
			end
			ST_FETCH: begin
				o_mem_read = 1'b1;
				if (i_mem_ok) begin
					ir_d = i_mem_rdata;
					state_d = ST_DECODE;
				end
			end
			ST_DECODE: begin
				state_d = cond_pass ? ST_EXEC : ST_FETCH;
				regs.pc_en = !cond_pass;  // skipped instruction
			end
			ST_EXEC: begin
				regs.pc_en = 1'b1;
				state_d = ST_FETCH;
				if (is_br) begin
					regs.pc_data = regs.pc + PC_AHEAD + {{6{ir[23]}}, ir[23:0], 2'b00};
					regs.wr_en = ir[24];  // bl
					regs.wr_sel = REG_LR;
					regs.wr_data = seq_pc;
				end else if (is_dp) begin
					regs.wr_en = i_alu_writes_rd;
					if (ir[20]) begin
						nzcv_d = i_alu_flags;
					end
				end else if (is_ls) begin
					o_mem_addr = xfer_addr;
					o_mem_read = ir[20];
					o_mem_write = !ir[20];
					regs.wr_data = i_mem_rdata;
					if (i_mem_ok) begin
						regs.base_en = !ir[24] || ir[21];
						regs.wr_en = ir[20];  // load beats base writeback
					end else begin
						regs.pc_en = 1'b0;  // hold until acknowledged
						state_d = ST_EXEC;
					end
				end
			end
			default: state_d = ST_INIT;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state <= ST_INIT;
			nzcv <= '0;
		end else begin
			state <= state_d;
			nzcv <= nzcv_d;
		end
		ir <= ir_d;
	end

endmodule

// File: hw/arm_core.sv
module arm_core #(
	parameter arm_pkg::word_t RESET_PC = 32'h0800_0000
) (
	input logic clk,
	input logic rstn,
	output arm_pkg::word_t o_mem_addr,
	output arm_pkg::word_t o_mem_wdata,
	input arm_pkg::word_t i_mem_rdata,
	output logic o_mem_read,
	output logic o_mem_write,
	input logic i_mem_ok
);
	import arm_pkg::*;

	logic sh_imm_form;
	word_t sh_value;
	logic [7:0] sh_amount;
	shift_t sh_kind;
	word_t sh_operand;
	logic sh_carry;
	alu_op_t alu_op;
	word_t alu_a;
	word_t alu_b;
	word_t alu_result;
	flags_t alu_flags;
	logic alu_writes_rd;
	flags_t flags;      // current nzcv

	reg_port_if regs ();

	arm_control #(
		.RESET_PC(RESET_PC)
	) u_control (
		.clk(clk), .rstn(rstn), .regs(regs.ctrl),
		.o_sh_imm_form(sh_imm_form), .o_sh_value(sh_value),
		.o_sh_amount(sh_amount), .o_sh_kind(sh_kind),
		.i_sh_operand(sh_operand), .i_sh_carry(sh_carry),
		.o_alu_op(alu_op), .o_alu_a(alu_a), .o_alu_b(alu_b),
		.i_alu_result(alu_result), .i_alu_flags(alu_flags),
		.i_alu_writes_rd(alu_writes_rd), .o_flags(flags),
		.o_mem_addr(o_mem_addr), .o_mem_wdata(o_mem_wdata), .i_mem_rdata(i_mem_rdata),
		.o_mem_read(o_mem_read), .o_mem_write(o_mem_write), .i_mem_ok(i_mem_ok)
	);

	arm_regfile u_regfile (.clk(clk), .rstn(rstn), .regs(regs.rf));

	arm_shifter u_shifter (
		.i_imm_form(sh_imm_form), .i_value(sh_value), .i_amount(sh_amount),
		.i_kind(sh_kind), .i_carry_in(flags[FLAG_C]),
		.o_operand(sh_operand), .o_carry(sh_carry)
	);

	arm_alu u_alu (
		.i_op(alu_op), .i_a(alu_a), .i_b(alu_b),
		.i_flags(flags), .i_shift_carry(sh_carry),
		.o_result(alu_result), .o_flags(alu_flags), .o_writes_rd(alu_writes_rd)
	);

endmodule

// File: hw/arm_regfile.sv
module arm_regfile (
	input logic clk,
	input logic rstn,
	reg_port_if.rf regs
);
	import arm_pkg::*;

	word_t gpr [0:14];  // r0 to r14
	word_t pc_q;

	function automatic word_t read_reg(reg_sel_t sel);
		if (sel == REG_PC) begin
			return pc_q + PC_AHEAD;
		end
		return gpr[sel];
	endfunction

	assign regs.rn_val = read_reg(regs.rn_sel);
	assign regs.rm_val = read_reg(regs.rm_sel);
	assign regs.rs_val = read_reg(regs.rs_sel);
	assign regs.rd_val = read_reg(regs.rd_sel);
	assign regs.pc = pc_q;

	// later assignments win: wr over base over pc_en
	always_ff @(posedge clk) begin
		if (!rstn) begin
			for (int i = 0; i < 15; i++) begin
				gpr[i] <= '0;
			end
			pc_q <= '0;  // loaded again in ST_INIT
		end else begin
			if (regs.pc_en) begin
				pc_q <= regs.pc_data;
			end
			if (regs.base_en) begin
				if (regs.base_sel == REG_PC) begin
					pc_q <= regs.base_data;
				end else begin
					gpr[regs.base_sel] <= regs.base_data;
				end
			end
			if (regs.wr_en) begin
				if (regs.wr_sel == REG_PC) begin
					pc_q <= regs.wr_data;  // acts as a jump
				end else begin
					gpr[regs.wr_sel] <= regs.wr_data;
				end
			end
		end
	end

endmodule

// File: run.sh
#!/bin/sh
# build and run the arm_core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module arm_core_tb -f vlog.f -o Varm_core_tb
./obj_dir/Varm_core_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Testbench failed" sim.log || ! grep -q "Testbench passed" sim.log; then
	exit 1
fi
exit 0

// File: vlog.f
common/arm_pkg.sv
common/reg_port_if.sv
hw/arm_regfile.sv
execute/arm_shifter.sv
execute/arm_alu.sv
hw/arm_control.sv
hw/arm_core.sv
bench/arm_core_properties.sv
bench/arm_core_tb.sv
